/* src/ucode_config.svh */
`ifndef UCODE_CONFIG_SVH
`define UCODE_CONFIG_SVH

////////////////////////////////////////
// Table and ROM geometry
////////////////////////////////////////

// Width of one opcode byte from the host
`define UCODE_OPCODE_W 8

// Micro-pc width, enough to reach every ROM word
`define UCODE_ADDR_W 9

// Words in the micro-op ROM
`define UCODE_ROM_DEPTH 512

////////////////////////////////////////
// Fixed flow addresses and codes
////////////////////////////////////////

// Start of the flow for opcodes without an entry
`define UCODE_FLOW_DEFAULT 278

// Byte that selects the extended table for the next opcode
`define UCODE_CB_PREFIX 8'hCB

`endif

/* src/ucodePkg.sv */
`include "ucode_config.svh"

package ucodePkg;

	////////////////////////////////////////
	// Flow control field
	////////////////////////////////////////

	// How the sequencer moves on after a word
	typedef enum logic [2:0]
	{
		ctlOp       = 3'd0,
		ctlInc      = 3'd1,
		ctlEof      = 3'd2,
		ctlIncEof   = 3'd3,
		ctlIncEofZ  = 3'd4,
		ctlIncEofNz = 3'd5,
		ctlIncEofC  = 3'd6,
		ctlUpdFlags = 3'd7
	} flowCtlT;

	////////////////////////////////////////
	// Datapath operation field
	////////////////////////////////////////

	typedef enum logic [4:0]
	{
		opNop     = 5'd0,
		opSma     = 5'd1,
		opSrm     = 5'd2,
		opInc16   = 5'd3,
		opDec16   = 5'd4,
		opSx16r   = 5'd5,
		opSrx16   = 5'd6,
		opAddx16  = 5'd7,
		opAddx16u = 5'd8,
		opSubx16  = 5'd9,
		opSpc     = 5'd10,
		opBit     = 5'd11,
		opShr     = 5'd12,
		opRrot    = 5'd13,
		opJcb     = 5'd14,
		opCeti    = 5'd15,
		opZ801bop = 5'd16
	} uopOpT;

	// Operand selector, x8 and x16 are datapath scratch registers
	typedef enum logic [3:0]
	{
		argNull = 4'd0,
		argA    = 4'd1,
		argB    = 4'd2,
		argC    = 4'd3,
		argPc   = 4'd4,
		argX8   = 4'd5,
		argX16  = 4'd6
	} uopArgT;

	// One ROM word
	typedef struct packed
	{
		flowCtlT ctl;
		uopOpT   op;
		uopArgT  arg;
	} uopT;

	typedef logic [`UCODE_ADDR_W-1:0] uAddrT;

endpackage

/* src/opcodeDispatch.sv */
`timescale 1ns/100ps
`include "ucode_config.svh"

module opcodeDispatch import ucodePkg::*;
(
	input  logic [`UCODE_OPCODE_W-1:0] opcode,
	input  logic                       cbSel,
	output uAddrT                      flowStart
);

	// Base table opcodes
	localparam logic [`UCODE_OPCODE_W-1:0] codeNop  = 8'h00;
	localparam logic [`UCODE_OPCODE_W-1:0] codeIncB = 8'h04;
	localparam logic [`UCODE_OPCODE_W-1:0] codeDecB = 8'h05;
	localparam logic [`UCODE_OPCODE_W-1:0] codeLdBn = 8'h06;
	localparam logic [`UCODE_OPCODE_W-1:0] codeIncC = 8'h0C;
	localparam logic [`UCODE_OPCODE_W-1:0] codeDecC = 8'h0D;
	localparam logic [`UCODE_OPCODE_W-1:0] codeLdCn = 8'h0E;
	localparam logic [`UCODE_OPCODE_W-1:0] codeJrNz = 8'h20;
	localparam logic [`UCODE_OPCODE_W-1:0] codeJrZ  = 8'h28;
	localparam logic [`UCODE_OPCODE_W-1:0] codeJrNc = 8'h30;
	localparam logic [`UCODE_OPCODE_W-1:0] codeLdAn = 8'h3E;
	localparam logic [`UCODE_OPCODE_W-1:0] codeAddB = 8'h80;
	localparam logic [`UCODE_OPCODE_W-1:0] codeSubB = 8'h90;
	localparam logic [`UCODE_OPCODE_W-1:0] codeDi   = 8'hF3;

	// Extended table opcodes
	localparam logic [`UCODE_OPCODE_W-1:0] codeRrFirst = 8'h18;
	localparam logic [`UCODE_OPCODE_W-1:0] codeRrHl    = 8'h1E;
	localparam logic [`UCODE_OPCODE_W-1:0] codeRrLast  = 8'h1F;
	localparam logic [`UCODE_OPCODE_W-1:0] codeSrlB    = 8'h38;
	localparam logic [`UCODE_OPCODE_W-1:0] codeBit7H   = 8'h7C;

	always_comb
	begin
		if (cbSel)
		begin
			// First matching item wins, so RR (hl) is carved out of the range
			case (opcode) inside
				codeBit7H:                 flowStart = uAddrT'(16);
				codeSrlB:                  flowStart = uAddrT'(505);
				codeRrHl:                  flowStart = '0;
				[codeRrFirst:codeRrLast]:  flowStart = uAddrT'(509);
				default:                   flowStart = '0;
			endcase
		end
		else
		begin
			case (opcode)
				codeLdAn:         flowStart = uAddrT'(26);
				codeLdBn:         flowStart = uAddrT'(60);
				codeLdCn:         flowStart = uAddrT'(23);
				codeIncB:         flowStart = uAddrT'(161);
				codeIncC:         flowStart = uAddrT'(32);
				codeDecB:         flowStart = uAddrT'(300);
				codeDecC:         flowStart = uAddrT'(48);
				codeAddB:         flowStart = uAddrT'(178);
				codeSubB:         flowStart = uAddrT'(132);
				codeJrNz:         flowStart = uAddrT'(17);
				codeJrZ:          flowStart = uAddrT'(106);
				codeJrNc:         flowStart = uAddrT'(414);
				codeNop:          flowStart = uAddrT'(162);
				codeDi:           flowStart = uAddrT'(163);
				`UCODE_CB_PREFIX: flowStart = uAddrT'(13);
				default:          flowStart = uAddrT'(`UCODE_FLOW_DEFAULT);
			endcase
		end
	end

endmodule

/* src/microcodeRom.sv */
`timescale 1ns/100ps
`include "ucode_config.svh"

module microcodeRom import ucodePkg::*;
(
	input  uAddrT uPc,
	output uopT   romWord
);

	always_comb
	begin
		case (uPc)
			////////////////////////////////////////
			// Prefix and extended flows
			////////////////////////////////////////

			// Prefix byte, fetch and hand over to the extended table
			13: romWord = '{ctlInc,      opSma,     argPc};
			14: romWord = '{ctlOp,       opNop,     argNull};
			15: romWord = '{ctlInc,      opJcb,     argNull};
			// BIT 7
			16: romWord = '{ctlEof,      opBit,     argNull};
			// SRL b
			505: romWord = '{ctlUpdFlags, opShr,    argNull};
			506: romWord = '{ctlEof,      opNop,    argNull};
			// RR r
			509: romWord = '{ctlUpdFlags, opRrot,   argNull};
			510: romWord = '{ctlEof,      opNop,    argNull};

			////////////////////////////////////////
			// Relative jumps
			////////////////////////////////////////

			// JR NZ, leaves early when z is set
			17: romWord = '{ctlInc,      opSma,     argPc};
			18: romWord = '{ctlOp,       opNop,     argNull};
			19: romWord = '{ctlIncEofZ,  opSrm,     argX8};
			20: romWord = '{ctlOp,       opSx16r,   argPc};
			21: romWord = '{ctlOp,       opAddx16,  argX8};
			22: romWord = '{ctlEof,      opSpc,     argX16};
			// JR Z
			106: romWord = '{ctlInc,      opSma,    argPc};
			107: romWord = '{ctlOp,       opNop,    argNull};
			108: romWord = '{ctlIncEofNz, opSrm,    argX8};
			109: romWord = '{ctlOp,       opSx16r,  argPc};
			110: romWord = '{ctlOp,       opAddx16, argX8};
			111: romWord = '{ctlEof,      opSpc,    argX16};
			// JR NC, offset comes straight from the fetched byte
			414: romWord = '{ctlInc,      opSma,    argPc};
			415: romWord = '{ctlIncEofC,  opSx16r,  argPc};
			416: romWord = '{ctlOp,       opAddx16, argX8};
			417: romWord = '{ctlOp,       opInc16,  argX16};
			418: romWord = '{ctlOp,       opSpc,    argX16};
			419: romWord = '{ctlEof,      opNop,    argNull};

			////////////////////////////////////////
			// Immediate loads
			////////////////////////////////////////

			// LD c,n
			23: romWord = '{ctlInc,      opSma,     argPc};
			24: romWord = '{ctlInc,      opNop,     argNull};
			25: romWord = '{ctlEof,      opSrm,     argC};
			// LD a,n
			26: romWord = '{ctlInc,      opSma,     argPc};
			27: romWord = '{ctlInc,      opNop,     argNull};
			28: romWord = '{ctlEof,      opSrm,     argA};
			// LD b,n
			60: romWord = '{ctlInc,      opSma,     argPc};
			61: romWord = '{ctlInc,      opNop,     argNull};
			62: romWord = '{ctlEof,      opSrm,     argB};

			////////////////////////////////////////
			// Arithmetic
			////////////////////////////////////////

			// INC c
			32: romWord = '{ctlUpdFlags, opInc16,   argC};
			33: romWord = '{ctlIncEof,   opNop,     argNull};
			// DEC c
			48: romWord = '{ctlUpdFlags, opDec16,   argC};
			49: romWord = '{ctlIncEof,   opNop,     argNull};
			// INC b, closes through the NOP word below
			161: romWord = '{ctlUpdFlags, opInc16,  argB};
			// DEC b
			300: romWord = '{ctlUpdFlags, opDec16,  argB};
			301: romWord = '{ctlIncEof,   opNop,    argNull};
			// SUB b
			132: romWord = '{ctlOp,       opSx16r,  argA};
			133: romWord = '{ctlUpdFlags, opSubx16, argB};
			134: romWord = '{ctlIncEof,   opSrx16,  argA};
			// ADD b
			178: romWord = '{ctlOp,       opSx16r,   argA};
			179: romWord = '{ctlUpdFlags, opAddx16u, argB};
			180: romWord = '{ctlIncEof,   opSrx16,   argA};

			////////////////////////////////////////
			// Single byte flows
			////////////////////////////////////////

			// NOP
			162: romWord = '{ctlIncEof,   opNop,    argNull};
			// DI
			163: romWord = '{ctlIncEof,   opCeti,   argNull};
			// Generic one byte op handled by the datapath
			`UCODE_FLOW_DEFAULT:     romWord = '{ctlUpdFlags, opZ801bop, argA};
			`UCODE_FLOW_DEFAULT + 1: romWord = '{ctlIncEof,   opNop,     argNull};

			// Unused words end the flow at once
			default: romWord = '{ctlEof, opNop, argNull};
		endcase
	end

	// Sequencer must stay inside the populated address space
	always_comb
	begin
		if (!$isunknown(uPc))
		begin
			romRange: assert (uPc <= `UCODE_ROM_DEPTH - 1)
				else $error("micro-pc %0d outside the ROM", uPc);
		end
	end

endmodule

/* src/microSequencer.sv */
`timescale 1ns/100ps
`include "ucode_config.svh"

module microSequencer import ucodePkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  logic  opReq,
	input  uAddrT flowStart,
	input  uopT   romWord,
	input  logic  flagZ,
	input  logic  flagC,
	output uAddrT uPc,
	output logic  cbSel,
	output logic  opAck,
	output logic  uopValid,
	output uopT   uop,
	output logic  pcInc
);

	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		stRun  = 2'd1,
		stAck  = 2'd2
	} seqStateT;

	seqStateT state;

	logic ctlEnds;
	logic ctlIncKind;
	logic jcbSeen;
	logic flowEnd;

	////////////////////////////////////////
	// Word decode
	////////////////////////////////////////

	// Conditional kinds end the flow only when their flag agrees
	always_comb
	begin
		case (romWord.ctl)
			ctlEof:
			begin
				ctlEnds    = 1'b1;
				ctlIncKind = 1'b0;
			end
			ctlInc:
			begin
				ctlEnds    = 1'b0;
				ctlIncKind = 1'b1;
			end
			ctlIncEof:
			begin
				ctlEnds    = 1'b1;
				ctlIncKind = 1'b1;
			end
			ctlIncEofZ:
			begin
				ctlEnds    = flagZ;
				ctlIncKind = 1'b1;
			end
			ctlIncEofNz:
			begin
				ctlEnds    = !flagZ;
				ctlIncKind = 1'b1;
			end
			ctlIncEofC:
			begin
				ctlEnds    = flagC;
				ctlIncKind = 1'b1;
			end
			default:
			begin
				ctlEnds    = 1'b0;
				ctlIncKind = 1'b0;
			end
		endcase
	end

	// Prefix jump closes this transaction as well
	assign jcbSeen = (romWord.op == opJcb);
	assign flowEnd = uopValid && (ctlEnds || jcbSeen);

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			uPc   <= '0;
			cbSel <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (opReq)
					begin
						uPc   <= flowStart;
						cbSel <= 1'b0;
						state <= stRun;
					end
				end
				stRun:
				begin
					uPc <= uPc + `UCODE_ADDR_W'(1);
					if (jcbSeen)
						cbSel <= 1'b1;
					if (flowEnd)
						state <= stAck;
				end
				stAck:
				begin
					// Hold the ack until the host lets go
					if (!opReq)
						state <= stIdle;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	assign uopValid = (state == stRun);
	assign opAck    = (state == stAck);
	assign uop      = romWord;
	assign pcInc    = uopValid && ctlIncKind;

	// Ack follows directly on the last micro-op of a flow
	ackAfterFlow: assert property (@(posedge clk) disable iff (!rstN)
		$rose(opAck) |-> !uopValid && $past(uopValid));

	// Micro-ops only stream outside idle and under a live request
	validNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		uopValid |-> (state != stIdle) && opReq);

endmodule

/* src/ucodeEngine.sv */
`timescale 1ns/100ps
`include "ucode_config.svh"

module ucodeEngine import ucodePkg::*;
(
	input  logic                       clk,
	input  logic                       rstN,
	input  logic                       opReq,
	input  logic [`UCODE_OPCODE_W-1:0] opcode,
	input  logic                       flagZ,
	input  logic                       flagC,
	output logic                       opAck,
	output logic                       uopValid,
	output uopT                        uop,
	output logic                       pcInc
);

	uAddrT flowStart;
	uAddrT uPc;
	uopT   romWord;
	logic  cbSel;

	// Opcode byte to flow start, table picked by the prefix state
	opcodeDispatch opcodeDispatchInst
	(
		.opcode    (opcode),
		.cbSel     (cbSel),
		.flowStart (flowStart)
	);

	microcodeRom microcodeRomInst
	(
		.uPc     (uPc),
		.romWord (romWord)
	);

	microSequencer microSequencerInst
	(
		.clk       (clk),
		.rstN      (rstN),
		.opReq     (opReq),
		.flowStart (flowStart),
		.romWord   (romWord),
		.flagZ     (flagZ),
		.flagC     (flagC),
		.uPc       (uPc),
		.cbSel     (cbSel),
		.opAck     (opAck),
		.uopValid  (uopValid),
		.uop       (uop),
		.pcInc     (pcInc)
	);

endmodule

/* testbench/ucodeEngineTb.sv */
`timescale 1ns/100ps
`include "ucode_config.svh"

module ucodeEngineTb
	import ucodePkg::*;
();

	localparam int watchdogCycles = 400;
	localparam int maxUops        = 16;
	localparam int ackLimit       = 40;

	logic                       clk;
	logic                       rstN;
	logic                       opReq;
	logic [`UCODE_OPCODE_W-1:0] opcode;
	logic                       flagZ;
	logic                       flagC;
	logic                       opAck;
	logic                       uopValid;
	uopT                        uop;
	logic                       pcInc;

	// Micro-ops captured during the last transaction
	flowCtlT ctlSeen [maxUops];
	uopOpT   opSeen  [maxUops];
	uopArgT  argSeen [maxUops];
	int      uopCount;
	int      incCount;
	int      errorCount;
	int      checkCount;
	integer  seed;

	ucodeEngine dut
	(
		.clk      (clk),
		.rstN     (rstN),
		.opReq    (opReq),
		.opcode   (opcode),
		.flagZ    (flagZ),
		.flagC    (flagC),
		.opAck    (opAck),
		.uopValid (uopValid),
		.uop      (uop),
		.pcInc    (pcInc)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		begin
			checkCount++;
			if (actual !== expected)
			begin
				errorCount++;
				$display("mismatch at time %0t: %s is %0d, expected %0d",
					$time, name, actual, expected);
			end
		end
	endtask

	// One full four-phase transaction, micro-ops logged until opAck
	task automatic sendOp(input logic [7:0] code, input logic z, input logic c);
		int waitCount;
		begin
			uopCount = 0;
			incCount = 0;
			waitCount = 0;
			@(negedge clk);
			opcode = code;
			flagZ  = z;
			flagC  = c;
			opReq  = 1'b1;
			@(negedge clk);
			while (opAck !== 1'b1 && waitCount < ackLimit)
			begin
				if (uopValid === 1'b1 && uopCount < maxUops)
				begin
					ctlSeen[uopCount] = uop.ctl;
					opSeen[uopCount]  = uop.op;
					argSeen[uopCount] = uop.arg;
					uopCount++;
					if (pcInc === 1'b1)
						incCount++;
				end
				waitCount++;
				@(negedge clk);
			end
			if (opAck !== 1'b1)
			begin
				errorCount++;
				$display("The DUT never raised opAck for opcode %h", code);
			end
			opReq = 1'b0;
			waitCount = 0;
			while (opAck !== 1'b0 && waitCount < ackLimit)
			begin
				waitCount++;
				@(negedge clk);
			end
			if (opAck !== 1'b0)
			begin
				errorCount++;
				$display("The DUT kept opAck high after opReq dropped, opcode %h", code);
			end
		end
	endtask

	// Immediate loads share one shape, only the target differs
	task automatic verifyLoadFlow(input uopArgT lastArg);
		begin
			checkValue("uop count", uopCount, 3);
			checkValue("uop[0].op", opSeen[0], opSma);
			checkValue("uop[1].op", opSeen[1], opNop);
			checkValue("uop[2].op", opSeen[2], opSrm);
			checkValue("uop[2].arg", argSeen[2], lastArg);
			checkValue("pcInc count", incCount, 2);
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic resetBehavior;
		begin
			repeat (2)
			begin
				@(negedge clk);
				checkValue("opAck", opAck, 0);
				checkValue("uopValid", uopValid, 0);
				checkValue("pcInc", pcInc, 0);
			end
			rstN = 1'b1;
			@(negedge clk);
			checkValue("opAck", opAck, 0);
			checkValue("uopValid", uopValid, 0);
			checkValue("pcInc", pcInc, 0);
		end
	endtask

	task automatic singleByteOps;
		begin
			// NOP
			sendOp(8'h00, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 1);
			checkValue("uop[0].ctl", ctlSeen[0], ctlIncEof);
			checkValue("uop[0].op", opSeen[0], opNop);
			checkValue("pcInc count", incCount, 1);
			// DI
			sendOp(8'hF3, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 1);
			checkValue("uop[0].op", opSeen[0], opCeti);
		end
	endtask

	task automatic immediateLoads;
		begin
			sendOp(8'h0E, 1'b0, 1'b0);
			verifyLoadFlow(argC);
			sendOp(8'h3E, 1'b0, 1'b0);
			verifyLoadFlow(argA);
			sendOp(8'h06, 1'b0, 1'b0);
			verifyLoadFlow(argB);
		end
	endtask

	task automatic relativeJumps;
		begin
			// JRNZ taken only with z clear
			sendOp(8'h20, 1'b1, 1'b0);
			checkValue("uop count", uopCount, 3);
			sendOp(8'h20, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 6);
			checkValue("uop[5].op", opSeen[5], opSpc);
			checkValue("uop[5].arg", argSeen[5], argX16);
			// JRZ is the mirror image
			sendOp(8'h28, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 3);
			sendOp(8'h28, 1'b1, 1'b0);
			checkValue("uop count", uopCount, 6);
			checkValue("uop[5].op", opSeen[5], opSpc);
			checkValue("uop[5].arg", argSeen[5], argX16);
			// JRNC not taken
			sendOp(8'h30, 1'b0, 1'b1);
			checkValue("uop count", uopCount, 2);
		end
	endtask

	task automatic prefixedOps;
		begin
			sendOp(`UCODE_CB_PREFIX, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 3);
			checkValue("uop[2].op", opSeen[2], opJcb);
			sendOp(8'h7C, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 1);
			checkValue("uop[0].op", opSeen[0], opBit);
			// SRL b
			sendOp(`UCODE_CB_PREFIX, 1'b0, 1'b0);
			sendOp(8'h38, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 2);
			checkValue("uop[0].op", opSeen[0], opShr);
			checkValue("uop[1].op", opSeen[1], opNop);
			// RR d
			sendOp(`UCODE_CB_PREFIX, 1'b0, 1'b0);
			sendOp(8'h1A, 1'b0, 1'b0);
			checkValue("uop[0].op", opSeen[0], opRrot);
			// Base table is back after one extended byte
			sendOp(8'h00, 1'b0, 1'b0);
			checkValue("uop count", uopCount, 1);
			checkValue("uop[0].ctl", ctlSeen[0], ctlIncEof);
			checkValue("uop[0].op", opSeen[0], opNop);
		end
	endtask

	task automatic unlistedOpcode;
		logic z;
		logic c;
		begin
			repeat (3)
			begin
				z = $random(seed);
				c = $random(seed);
				sendOp(8'h76, z, c);
				checkValue("uop count", uopCount, 2);
				checkValue("uop[0].ctl", ctlSeen[0], ctlUpdFlags);
				checkValue("uop[0].op", opSeen[0], opZ801bop);
				checkValue("uop[1].ctl", ctlSeen[1], ctlIncEof);
				checkValue("uop[1].op", opSeen[1], opNop);
			end
		end
	endtask

	////////////////////////////////////////
	// Run
	////////////////////////////////////////

	initial
	begin
		clk        = 1'b0;
		rstN       = 1'b0;
		opReq      = 1'b0;
		opcode     = '0;
		flagZ      = 1'b0;
		flagC      = 1'b0;
		uopCount   = 0;
		incCount   = 0;
		errorCount = 0;
		checkCount = 0;
		seed       = 43;

		resetBehavior();
		singleByteOps();
		immediateLoads();
		relativeJumps();
		prefixedOps();
		unlistedOpcode();

		@(negedge clk);
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Watchdog, about four times the length of all tests
	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("The run timed out after %0d clock cycles", watchdogCycles);
		$display("Test failed");
		$finish;
	end

endmodule

/* ucodeEngine.f */
+incdir+src
src/ucodePkg.sv
src/opcodeDispatch.sv
src/microcodeRom.sv
src/microSequencer.sv
src/ucodeEngine.sv
testbench/ucodeEngineTb.sv
